/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CPU_DATA_W   32 // one data word.
`define CPU_REG_AW   5  // register index.
`define CPU_IM_AW    10 // instruction word address.
`define CPU_DM_AW    12 // data word address.

`define CPU_CYCLE_W  64
`define CPU_INS_W    32

`endif

/* common/isa_pkg.sv */
`include "cpu_defs.svh"

package isa_pkg;

  typedef logic [`CPU_DATA_W-1:0]  word_t;
  typedef logic [`CPU_REG_AW-1:0]  reg_idx_t;
  typedef logic [`CPU_IM_AW-1:0]   im_addr_t;
  typedef logic [`CPU_DM_AW-1:0]   dm_addr_t;
  typedef logic [1:0]              shift_t;     // index scale for indexed memory access.
  typedef logic [`CPU_CYCLE_W-1:0] cycle_cnt_t;
  typedef logic [`CPU_INS_W-1:0]   ins_cnt_t;

  typedef enum logic [5:0] {
    ALU_REG = 6'b100000,
    ADDI    = 6'b101000,
    ORI     = 6'b101100,
    XORI    = 6'b101011,
    MOVI    = 6'b100010,
    LWI     = 6'b000010,
    SWI     = 6'b001010,
    MEM_IDX = 6'b011100
  } opcode_e;

  typedef enum logic [4:0] {
    ADD  = 5'b00000,
    SUB  = 5'b00001,
    AND  = 5'b00010,
    XOR  = 5'b00011,
    OR   = 5'b00100,
    SLLI = 5'b01000,
    SRLI = 5'b01001
  } alu_sub_e;

  typedef enum logic [7:0] {
    LW = 8'h02,
    SW = 8'h0a
  } mem_sub_e;

  typedef struct packed {
    logic        spare;  // bit 31 is not decoded.
    logic [5:0]  opcode;
    reg_idx_t    rt;
    reg_idx_t    ra;
    logic [14:0] low;    // rb, sv and the sub-opcodes, or imm15.
  } instr_t;

endpackage

/* common/ctrl_pkg.sv */
package ctrl_pkg;

  typedef enum logic [2:0] {
    IF,
    ID,
    EX,
    MEM,
    WB
  } phase_e;

  typedef enum logic [1:0] {
    IMM5_ZE,
    IMM15_SE,
    IMM15_ZE,
    IMM20_SE
  } imm_kind_e;

  // register write-back source.
  typedef enum logic {
    ALU,
    MEMORY
  } wb_src_e;

endpackage

/* design/pc_tick.sv */
`timescale 1ns/1ps

module pc_tick (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                system_enable,
  input  logic                pc_advance,
  output isa_pkg::im_addr_t   pc,
  output isa_pkg::cycle_cnt_t cycle_cnt
);
  import isa_pkg::*;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= '0;
      cycle_cnt <= '0;
    end else begin
      if (pc_advance) begin
        pc <= pc + im_addr_t'(1); // wraps at the end of instruction memory.
      end
      if (system_enable) begin
        cycle_cnt <= cycle_cnt + cycle_cnt_t'(1);
      end
    end
  end

  // a retiring instruction was fetched four cycles earlier in an enabled IF.
  a_no_frozen_advance : assert property (
    @(posedge clk) disable iff (!arst_n)
    pc_advance |-> $past(system_enable, 4)
  );

endmodule

/* controller/ir_controller.sv */
`timescale 1ns/1ps

module ir_controller (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                system_enable,
  input  isa_pkg::word_t      instruction,
  input  isa_pkg::im_addr_t   pc,
  output logic                im_read,
  output isa_pkg::im_addr_t   im_addr,
  output logic                dm_read,
  output logic                dm_write,
  output logic                reg_read,
  output logic                reg_write,
  output logic                alu_exec,
  output logic                pc_advance,
  output isa_pkg::reg_idx_t   read_addr1,
  output isa_pkg::reg_idx_t   read_addr2,
  output isa_pkg::reg_idx_t   write_addr,
  output isa_pkg::opcode_e    opcode,
  output isa_pkg::alu_sub_e   alu_sub,
  output isa_pkg::shift_t     sv,
  output logic [4:0]          imm5,
  output logic [14:0]         imm15,
  output logic [19:0]         imm20,
  output ctrl_pkg::imm_kind_e imm_kind,
  output logic                use_imm,
  output logic                addr_use_index,
  output ctrl_pkg::wb_src_e   wb_src,
  output isa_pkg::ins_cnt_t   ins_cnt
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  phase_e   phase;
  instr_t   ir_q;
  instr_t   cur;
  mem_sub_e mem_sub;
  logic     is_load;
  logic     is_store;
  logic     alu_ok;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // phase machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase   <= IF;
      ins_cnt <= '0;
    end else begin
      case (phase)
        IF: begin
          if (system_enable) begin
            phase <= ID; // a frozen core waits here.
          end
        end
        ID:  phase <= EX;
        EX:  phase <= MEM;
        MEM: phase <= WB;
        WB: begin
          phase   <= IF;
          ins_cnt <= ins_cnt + ins_cnt_t'(1);
        end
        default: phase <= IF;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == ID) begin
      ir_q <= instr_t'(instruction);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign cur            = (phase == ID) ? instr_t'(instruction) : ir_q; // memory word is live in ID.
  assign opcode         = opcode_e'(cur.opcode);
  assign alu_sub        = alu_sub_e'(cur.low[4:0]);
  assign mem_sub        = mem_sub_e'(cur.low[7:0]);
  assign sv             = cur.low[9:8];
  assign imm5           = cur.low[14:10];
  assign imm15          = cur.low;
  assign imm20          = {cur.ra, cur.low};
  assign addr_use_index = (opcode == MEM_IDX);
  assign is_load        = (opcode == LWI) || (addr_use_index && (mem_sub == LW));
  assign is_store       = (opcode == SWI) || (addr_use_index && (mem_sub == SW));
  assign wb_src         = is_load ? MEMORY : ALU;

  always_comb begin
    alu_ok   = 1'b1;
    use_imm  = 1'b1;
    imm_kind = IMM15_SE;
    case (opcode)
      ALU_REG: begin
        use_imm  = (alu_sub == SLLI) || (alu_sub == SRLI); // shift amount sits in imm5.
        imm_kind = IMM5_ZE;
        alu_ok   = alu_sub inside {ADD, SUB, AND, OR, XOR, SLLI, SRLI};
      end
      ADDI:      imm_kind = IMM15_SE;
      ORI, XORI: imm_kind = IMM15_ZE;
      MOVI:      imm_kind = IMM20_SE;
      default:   alu_ok   = 1'b0; // memory ops and unknown opcodes.
    endcase
  end

  // an indexed store reads rb in ID and rereads rt in EX for the store data.
  assign read_addr1 = cur.ra;
  assign read_addr2 = (is_store && (!addr_use_index || (phase == EX))) ? cur.rt : cur.low[14:10];
  assign write_addr = cur.rt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign im_read    = (phase == IF) && system_enable;
  assign im_addr    = pc;
  assign reg_read   = (phase == ID) || ((phase == EX) && is_store && addr_use_index);
  assign alu_exec   = (phase == EX);
  assign dm_read    = (phase == MEM) && is_load;
  assign dm_write   = (phase == MEM) && is_store;
  assign reg_write  = (phase == WB) && (is_load || alu_ok);
  assign pc_advance = (phase == WB);

  a_dm_exclusive : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(dm_read && dm_write)
  );

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regfile (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              reg_read,
  input  logic              reg_write,
  input  isa_pkg::reg_idx_t read_addr1,
  input  isa_pkg::reg_idx_t read_addr2,
  input  isa_pkg::reg_idx_t write_addr,
  input  isa_pkg::word_t    write_data,
  output isa_pkg::word_t    read_data1,
  output isa_pkg::word_t    read_data2
);
  import isa_pkg::*;

  localparam int DEPTH = 1 << `CPU_REG_AW;

  word_t regs [DEPTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write) begin
      regs[write_addr] <= write_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      read_data1 <= '0;
      read_data2 <= '0;
    end else if (reg_read) begin
      read_data1 <= regs[read_addr1]; // held until the next read.
      read_data2 <= regs[read_addr2];
    end
  end

endmodule

/* design/alu32.sv */
`timescale 1ns/1ps

module alu32 (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              alu_exec,
  input  isa_pkg::opcode_e  opcode,
  input  isa_pkg::alu_sub_e alu_sub,
  input  isa_pkg::word_t    operand_a,
  input  isa_pkg::word_t    operand_b,
  output isa_pkg::word_t    alu_result,
  output logic              overflow
);
  import isa_pkg::*;

  localparam int MSB = $bits(word_t) - 1;

  word_t sum;
  word_t diff;
  logic  add_ovf;
  logic  sub_ovf;
  word_t result_next;
  logic  ovf_next;

  assign sum     = operand_a + operand_b;
  assign diff    = operand_a - operand_b;
  assign add_ovf = (operand_a[MSB] == operand_b[MSB]) && (sum[MSB] != operand_a[MSB]);
  assign sub_ovf = (operand_a[MSB] != operand_b[MSB]) && (diff[MSB] != operand_a[MSB]);

  always_comb begin
    result_next = alu_result;
    ovf_next    = 1'b0;
    case (opcode)
      ALU_REG: begin
        case (alu_sub)
          ADD: begin
            result_next = sum;
            ovf_next    = add_ovf;
          end
          SUB: begin
            result_next = diff;
            ovf_next    = sub_ovf;
          end
          AND:     result_next = operand_a & operand_b;
          OR:      result_next = operand_a | operand_b;
          XOR:     result_next = operand_a ^ operand_b;
          SLLI:    result_next = operand_a << operand_b[4:0];
          SRLI:    result_next = operand_a >> operand_b[4:0];
          default: result_next = alu_result;
        endcase
      end
      ADDI: begin
        result_next = sum;
        ovf_next    = add_ovf;
      end
      ORI:     result_next = operand_a | operand_b;
      XORI:    result_next = operand_a ^ operand_b;
      MOVI:    result_next = operand_b;
      default: ovf_next    = overflow; // loads and stores leave the flag as it was.
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_result <= '0;
      overflow   <= 1'b0;
    end else if (alu_exec) begin
      alu_result <= result_next;
      overflow   <= ovf_next;
    end
  end

endmodule

/* design/alu12.sv */
`timescale 1ns/1ps

module alu12 (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              alu_exec,
  input  isa_pkg::word_t    base,
  input  isa_pkg::word_t    index,
  input  logic [14:0]       offset,
  input  isa_pkg::shift_t   sv,
  input  logic              addr_use_index,
  output isa_pkg::dm_addr_t dm_addr
);
  import isa_pkg::*;

  word_t offset_ext;
  word_t addr_full;

  assign offset_ext = {{($bits(word_t) - 15){offset[14]}}, offset};
  assign addr_full  = base + (addr_use_index ? (index << sv) : offset_ext);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dm_addr <= '0;
    end else if (alu_exec) begin
      dm_addr <= dm_addr_t'(addr_full); // upper bits fall off the 12-bit word space.
    end
  end

  // the scale and index register must be resolved when an indexed address is formed.
  a_index_known : assert property (
    @(posedge clk) disable iff (!arst_n)
    (alu_exec && addr_use_index) |-> !$isunknown({sv, index})
  );

endmodule

/* design/datapath_select.sv */
`timescale 1ns/1ps

module datapath_select (
  input  logic [4:0]          imm5,
  input  logic [14:0]         imm15,
  input  logic [19:0]         imm20,
  input  ctrl_pkg::imm_kind_e imm_kind,
  input  logic                use_imm,
  input  isa_pkg::word_t      read_data2,
  input  ctrl_pkg::wb_src_e   wb_src,
  input  isa_pkg::word_t      alu_result,
  input  isa_pkg::word_t      dm_out,
  output isa_pkg::word_t      operand_b,
  output isa_pkg::word_t      write_data
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int W = $bits(word_t);

  word_t imm_ext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // immediate and operand choice
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (imm_kind)
      IMM5_ZE:  imm_ext = word_t'(imm5);
      IMM15_SE: imm_ext = {{(W - 15){imm15[14]}}, imm15};
      IMM15_ZE: imm_ext = word_t'(imm15);
      default:  imm_ext = {{(W - 20){imm20[19]}}, imm20};
    endcase
  end

  assign operand_b = use_imm ? imm_ext : read_data2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write-back choice
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign write_data = (wb_src == MEMORY) ? dm_out : alu_result; // loads return in WB.

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                system_enable,
  input  isa_pkg::word_t      instruction,
  input  isa_pkg::word_t      dm_out,
  output logic                im_read,
  output isa_pkg::im_addr_t   im_addr,
  output logic                dm_read,
  output logic                dm_write,
  output isa_pkg::dm_addr_t   dm_addr,
  output isa_pkg::word_t      dm_in,
  output logic                overflow,
  output isa_pkg::cycle_cnt_t cycle_cnt,
  output isa_pkg::ins_cnt_t   ins_cnt
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal nets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  im_addr_t  pc;
  logic      pc_advance;
  logic      reg_read;
  logic      reg_write;
  logic      alu_exec;
  reg_idx_t  read_addr1;
  reg_idx_t  read_addr2;
  reg_idx_t  write_addr;
  opcode_e   opcode;
  alu_sub_e  alu_sub;
  shift_t    sv;
  logic [4:0]  imm5;
  logic [14:0] imm15;
  logic [19:0] imm20;
  imm_kind_e imm_kind;
  logic      use_imm;
  logic      addr_use_index;
  wb_src_e   wb_src;
  word_t     read_data1;
  word_t     read_data2;
  word_t     operand_b;
  word_t     alu_result;
  word_t     write_data;

  assign dm_in = read_data2; // rt is on the second read port during a store.

  pc_tick i_pc_tick (
    .clk           (clk),
    .arst_n        (arst_n),
    .system_enable (system_enable),
    .pc_advance    (pc_advance),
    .pc            (pc),
    .cycle_cnt     (cycle_cnt)
  );

  ir_controller i_ir_controller (
    .clk            (clk),
    .arst_n         (arst_n),
    .system_enable  (system_enable),
    .instruction    (instruction),
    .pc             (pc),
    .im_read        (im_read),
    .im_addr        (im_addr),
    .dm_read        (dm_read),
    .dm_write       (dm_write),
    .reg_read       (reg_read),
    .reg_write      (reg_write),
    .alu_exec       (alu_exec),
    .pc_advance     (pc_advance),
    .read_addr1     (read_addr1),
    .read_addr2     (read_addr2),
    .write_addr     (write_addr),
    .opcode         (opcode),
    .alu_sub        (alu_sub),
    .sv             (sv),
    .imm5           (imm5),
    .imm15          (imm15),
    .imm20          (imm20),
    .imm_kind       (imm_kind),
    .use_imm        (use_imm),
    .addr_use_index (addr_use_index),
    .wb_src         (wb_src),
    .ins_cnt        (ins_cnt)
  );

  regfile i_regfile (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_read   (reg_read),
    .reg_write  (reg_write),
    .read_addr1 (read_addr1),
    .read_addr2 (read_addr2),
    .write_addr (write_addr),
    .write_data (write_data),
    .read_data1 (read_data1),
    .read_data2 (read_data2)
  );

  alu32 i_alu32 (
    .clk        (clk),
    .arst_n     (arst_n),
    .alu_exec   (alu_exec),
    .opcode     (opcode),
    .alu_sub    (alu_sub),
    .operand_a  (read_data1),
    .operand_b  (operand_b),
    .alu_result (alu_result),
    .overflow   (overflow)
  );

  alu12 i_alu12 (
    .clk            (clk),
    .arst_n         (arst_n),
    .alu_exec       (alu_exec),
    .base           (read_data1),
    .index          (read_data2),
    .offset         (imm15),
    .sv             (sv),
    .addr_use_index (addr_use_index),
    .dm_addr        (dm_addr)
  );

  datapath_select i_datapath_select (
    .imm5       (imm5),
    .imm15      (imm15),
    .imm20      (imm20),
    .imm_kind   (imm_kind),
    .use_imm    (use_imm),
    .read_data2 (read_data2),
    .wb_src     (wb_src),
    .alu_result (alu_result),
    .dm_out     (dm_out),
    .operand_b  (operand_b),
    .write_data (write_data)
  );

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;
  import isa_pkg::*;

  localparam int IM_DEPTH     = 1 << `CPU_IM_AW;
  localparam int DM_DEPTH     = 1 << `CPU_DM_AW;
  localparam int PAT_DEPTH    = 512;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_FREEZE   = 4;
  localparam int PARK_CYCLES  = 3;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       system_enable;
  word_t      instruction;
  word_t      dm_out;
  logic       im_read;
  im_addr_t   im_addr;
  logic       dm_read;
  logic       dm_write;
  dm_addr_t   dm_addr;
  word_t      dm_in;
  logic       overflow;
  cycle_cnt_t cycle_cnt;
  ins_cnt_t   ins_cnt;

  word_t       imem [IM_DEPTH];
  word_t       dmem [DM_DEPTH];
  logic [31:0] pat  [0:PAT_DEPTH-1];
  dm_addr_t    st_addr_q [$];
  word_t       st_data_q [$];

  integer seed         = 32'hdaa4ce10;
  int     ptr          = 1;
  int     errors       = 0;
  int     frozen       = 0;
  int     n_pass       = 0;
  int     n_fail       = 0;
  int     setup_errors = 0;
  int     watch_cycles = 0;

  always #4 clk = ~clk;

  cpu_top i_cpu_top (
    .clk           (clk),
    .arst_n        (arst_n),
    .system_enable (system_enable),
    .instruction   (instruction),
    .dm_out        (dm_out),
    .im_read       (im_read),
    .im_addr       (im_addr),
    .dm_read       (dm_read),
    .dm_write      (dm_write),
    .dm_addr       (dm_addr),
    .dm_in         (dm_in),
    .overflow      (overflow),
    .cycle_cnt     (cycle_cnt),
    .ins_cnt       (ins_cnt)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (im_read) begin
      instruction <= imem[im_addr]; // valid in ID.
    end
  end

  always @(posedge clk) begin
    if (dm_read) begin
      dm_out <= dmem[dm_addr]; // valid in WB.
    end
    if (dm_write) begin
      dmem[dm_addr] <= dm_in;
      st_addr_q.push_back(dm_addr);
      st_data_q.push_back(dm_in);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input dm_addr_t exp, input dm_addr_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_pc(input string name, input im_addr_t exp, input im_addr_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input ins_cnt_t exp, input ins_cnt_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cycles(input string name, input cycle_cnt_t exp, input cycle_cnt_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int budget_cycles(input int tests);
    int idx;
    int t;
    int n;
    int p;
    int s;
    int total;
    idx   = 1;
    total = 0;
    for (t = 0; t < tests; t++) begin
      n      = pat[idx];
      idx   += 1 + n;
      p      = pat[idx];
      idx   += 1 + 2 * p;
      s      = pat[idx];
      idx   += 3 + 2 * s;
      total += RESET_CYCLES + 2 + n * (5 + MAX_FREEZE) + PARK_CYCLES;
    end
    return total + 100;
  endfunction

  task automatic apply_reset();
    int c;
    @(posedge clk);
    arst_n        <= 1'b0;
    system_enable <= 1'b0;
    for (c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      check_flag("im_read", 1'b0, im_read);
      check_flag("dm_read", 1'b0, dm_read);
      check_flag("dm_write", 1'b0, dm_write);
      check_flag("overflow", 1'b0, overflow);
      check_count("ins_cnt", '0, ins_cnt);
      check_cycles("cycle_cnt", '0, cycle_cnt);
      @(posedge clk);
    end
    arst_n        <= 1'b1;
    system_enable <= 1'b1; // first fetch comes in the next cycle.
  endtask

  task automatic run_program(input int n, input logic [31:0] ovf_mask);
    int i;
    int w;
    int k;
    for (i = 0; i < n; i++) begin
      @(negedge clk);
      check_flag("im_read", 1'b1, im_read);
      check_pc("im_addr", im_addr_t'(i), im_addr);
      check_cycles("cycle_cnt", cycle_cnt_t'(5 * i), cycle_cnt);
      check_count("ins_cnt", ins_cnt_t'(i), ins_cnt);
      if (i == 0) begin
        check_flag("dm_read", 1'b0, dm_read);
        check_flag("dm_write", 1'b0, dm_write);
        check_flag("overflow", 1'b0, overflow);
      end else begin
        check_flag("overflow", ovf_mask[i-1], overflow);
      end
      for (w = 0; w < 4; w++) begin
        @(negedge clk);
        check_flag("im_read", 1'b0, im_read); // ID, EX, MEM and WB.
      end
      @(posedge clk);
      if (i == n - 1) begin
        system_enable <= 1'b0; // park the core in IF.
      end else if (($unsigned($random(seed)) % 4) == 0) begin
        k = 1 + ($unsigned($random(seed)) % MAX_FREEZE);
        system_enable <= 1'b0;
        repeat (k) begin
          @(negedge clk);
          check_flag("im_read", 1'b0, im_read);
          check_cycles("cycle_cnt", cycle_cnt_t'(5 * (i + 1)), cycle_cnt);
          check_count("ins_cnt", ins_cnt_t'(i + 1), ins_cnt);
          @(posedge clk);
        end
        system_enable <= 1'b1;
        frozen += k;
      end
    end
  endtask

  task automatic run_test(input int num);
    int          n;
    int          p;
    int          s;
    int          j;
    int          a;
    int          st_base;
    ins_cnt_t    exp_ins;
    logic [31:0] ovf_mask;
    errors = 0;
    frozen = 0;
    n      = pat[ptr];
    for (a = 0; a < IM_DEPTH; a++) begin
      imem[a] = $random(seed);
    end
    for (a = 0; a < n; a++) begin
      imem[a] = pat[ptr + 1 + a];
    end
    ptr += 1 + n;
    for (a = 0; a < DM_DEPTH; a++) begin
      dmem[a] = $random(seed);
    end
    p = pat[ptr];
    ptr++;
    for (j = 0; j < p; j++) begin
      dmem[dm_addr_t'(pat[ptr])] = pat[ptr + 1];
      ptr += 2;
    end
    s       = pat[ptr];
    st_base = ptr + 1;
    ptr    += 1 + 2 * s;
    exp_ins  = ins_cnt_t'(pat[ptr]);
    ovf_mask = pat[ptr + 1];
    ptr     += 2;
    st_addr_q.delete();
    st_data_q.delete();

    apply_reset();
    run_program(n, ovf_mask);

    repeat (PARK_CYCLES) begin
      @(negedge clk);
      check_flag("im_read", 1'b0, im_read);
    end
    check_count("ins_cnt", exp_ins, ins_cnt);
    check_cycles("cycle_cnt", cycle_cnt_t'(5 * n), cycle_cnt);
    if (n > 0) begin
      check_flag("overflow", ovf_mask[n-1], overflow);
    end

    if (st_addr_q.size() != s) begin
      $display("test %0d saw %0d data-memory stores where %0d were expected",
               num, st_addr_q.size(), s);
      errors++;
    end
    for (j = 0; (j < s) && (j < st_addr_q.size()); j++) begin
      check_addr("dm_addr", dm_addr_t'(pat[st_base + 2 * j]), st_addr_q[j]);
      check_word("dm_in", word_t'(pat[st_base + 2 * j + 1]), st_data_q[j]);
    end

    $display("test %0d: %0d instructions, %0d stores, %0d frozen cycles, %0d errors",
             num, n, s, frozen, errors);
    if (errors == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  initial begin : main_flow
    int t;
    int num_tests;
    arst_n        <= 1'b0;
    system_enable <= 1'b0;
    instruction   <= '0;
    dm_out        <= '0;
    $readmemh("bench/cpu_patterns.txt", pat);
    if ($isunknown(pat[0]) || (pat[0] == 0)) begin
      $display("pattern file bench/cpu_patterns.txt is missing or holds no tests");
      setup_errors = 1;
    end else begin
      num_tests    = pat[0];
      watch_cycles = budget_cycles(num_tests);
      for (t = 1; t <= num_tests; t++) begin
        run_test(t);
      end
    end
    $display("tests clean: %0d, tests with errors: %0d", n_pass, n_fail);
    if ((setup_errors == 0) && (n_fail == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // the budget covers every instruction at its longest freeze.
  initial begin : watchdog
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles and is stopped", watch_cycles);
    $display("test failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
design/pc_tick.sv
controller/ir_controller.sv
design/regfile.sv
design/alu32.sv
design/alu12.sv
design/datapath_select.sv
design/cpu_top.sv
bench/cpu_tb.sv

/* bench/cpu_patterns.txt */
// per test: n, n instruction words, p, p preload pairs (address data),
// s, s expected store pairs (address data) in order, final ins_cnt, overflow mask by instruction
00000004
// register ALU operations
00000010
44112345 4420F0F0 40308800 14300010 40408801 14400011 40508802 14500012
40608804 14600013 40708803 14700014 4080B008 14800015 40945009 14900016
00000000
00000007
010 00021435 011 00003255 012 00002040 013 0001F3F5
014 0001D3B5 015 12345000 016 00000123
00000010 00000000
// immediate forms
0000000A
441FFFFD 14100020 5020FFFB 14200021 58304001 14300022 5640FFFF 14400023 50503FFF 14508030
00000000
00000005
020 FFFFFFFD 021 FFFFFFF8 022 00004001 023 FFFF8002 02D 00003FFF
0000000A 00000000
// loads and indexed addressing
0000000B
04100040 14100041 44200100 44300001 38410E02 38410C0A 38110D0A 38410F0A 4457FF00 38628F02 14600042
00000003
040 CAFEF00D 104 13579BDF F08 0BADBEEF
00000005
041 CAFEF00D 101 13579BDF 102 CAFEF00D 108 13579BDF 042 0BADBEEF
0000000B 00000000
// overflow
0000000C
441FFFFF 40208409 44300001 40410C00 14400050 40510C02 14500051 40620C01 50710001 40831C03 14800052 14600053
00000000
00000004
050 80000000 051 00000001 052 FFFFFFFF 053 7FFFFFFF
0000000C 00000198
